// ==== design/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    ////////////////////
    // line geometry

    localparam int WORDS_PER_LINE = 4;
    localparam int OFFSET_BITS    = 2;    // word select within a line

    ////////////////////
    // payload types

    typedef logic [31:0] addr_t;          // word address, not byte
    typedef logic [31:0] word_t;

    // word 0 sits in the low bits
    typedef logic [WORDS_PER_LINE*$bits(word_t)-1:0] line_t;

endpackage

`default_nettype wire

// ==== design/line_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module line_mem #(
    parameter int MEM_LINES   = 256,
    parameter int READ_DELAY  = 10,
    parameter int WRITE_DELAY = 10,
    parameter int READY_HOLD  = 3
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   mem_rd,
    input  wire                   mem_wr,
    input  wire cache_pkg::addr_t mem_addr,
    input  wire cache_pkg::word_t mem_wdata,
    output cache_pkg::line_t      mem_line,
    output logic                  mem_ready,
    output logic                  mem_busy
);

    import cache_pkg::*;

    localparam int MEM_WORDS = MEM_LINES * WORDS_PER_LINE;
    localparam int WA_BITS   = $clog2(MEM_WORDS);
    localparam int WORD_W    = $bits(word_t);
    localparam int RW_MAX    = (READ_DELAY > WRITE_DELAY) ? READ_DELAY : WRITE_DELAY;
    localparam int MAX_DELAY = (RW_MAX > READY_HOLD) ? RW_MAX : READY_HOLD;
    localparam int CNT_W     = $clog2(MAX_DELAY + 1);

    typedef enum logic [1:0] {
        ph_idle,
        ph_read,
        ph_hold,
        ph_write
    } phase_t;

    phase_t             phase;
    logic [CNT_W-1:0]   cnt;
    logic               expire;
    logic [WA_BITS-1:0] word_addr;    // upper address bits alias
    logic [WA_BITS-1:0] line_base;
    word_t              wdata_q;
    line_t              line_q;
    word_t              mem [MEM_WORDS];

    assign expire    = (cnt == '0);
    assign line_base = {word_addr[WA_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            phase <= ph_idle;
            cnt   <= '0;
        end else begin
            case (phase)
                ph_idle: begin
                    if (mem_rd) begin
                        phase <= ph_read;
                        cnt   <= CNT_W'(READ_DELAY - 1);
                    end else if (mem_wr) begin
                        phase <= ph_write;
                        cnt   <= CNT_W'(WRITE_DELAY - 1);
                    end
                end
                ph_read: begin
                    if (expire) begin
                        phase <= ph_hold;
                        cnt   <= CNT_W'(READY_HOLD - 1);
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin    // hold and write both end in idle
                    if (expire) begin
                        phase <= ph_idle;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == ph_idle && (mem_rd || mem_wr)) begin
            word_addr <= mem_addr[WA_BITS-1:0];
            wdata_q   <= mem_wdata;
        end
        if (phase == ph_read && expire) begin
            for (int i = 0; i < WORDS_PER_LINE; i++) begin
                line_q[i*WORD_W +: WORD_W] <= mem[line_base + WA_BITS'(i)];
            end
        end
        if (phase == ph_write && expire) begin
            mem[word_addr] <= wdata_q;    // write lands at end of delay
        end
    end

    assign mem_ready = (phase == ph_hold);
    assign mem_busy  = (phase != ph_idle);
    assign mem_line  = mem_ready ? line_q : '0;

    // controller must wait out the previous operation, ready hold included
    a_strobe_legal: assert property (@(posedge clk) disable iff (!rst)
        (mem_rd || mem_wr) |-> !mem_busy && !(mem_rd && mem_wr));

endmodule

`default_nettype wire

// ==== design/tag_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module tag_store #(
    parameter int SETS = 16
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   lookup,
    input  wire cache_pkg::addr_t addr,
    input  wire                   fill,
    input  wire cache_pkg::addr_t fill_addr,
    output logic                  hit
);

    import cache_pkg::*;

    localparam int IDX_BITS = $clog2(SETS);
    localparam int TAG_LSB  = OFFSET_BITS + IDX_BITS;
    localparam int TAG_BITS = $bits(addr_t) - TAG_LSB;

    logic [SETS-1:0]     valid;
    logic [TAG_BITS-1:0] tags [SETS];
    logic [IDX_BITS-1:0] idx;
    logic [IDX_BITS-1:0] fill_idx;
    logic [TAG_BITS-1:0] tag;
    logic [TAG_BITS-1:0] fill_tag;

    assign idx      = addr[OFFSET_BITS +: IDX_BITS];
    assign tag      = addr[$bits(addr_t)-1:TAG_LSB];
    assign fill_idx = fill_addr[OFFSET_BITS +: IDX_BITS];
    assign fill_tag = fill_addr[$bits(addr_t)-1:TAG_LSB];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid <= '0;
            hit   <= 1'b0;
        end else begin
            hit <= lookup && valid[idx] && (tags[idx] == tag);    // one cycle after lookup
            if (fill) begin
                valid[fill_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tags[fill_idx] <= fill_tag;
        end
    end

endmodule

`default_nettype wire

// ==== design/data_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module data_store #(
    parameter int SETS = 16
) (
    input  wire                   clk,
    input  wire                   lookup,
    input  wire cache_pkg::addr_t addr,
    input  wire                   fill,
    input  wire cache_pkg::addr_t fill_addr,
    input  wire cache_pkg::line_t fill_line,
    input  wire                   update,
    input  wire cache_pkg::word_t update_word,
    output cache_pkg::word_t      word
);

    import cache_pkg::*;

    localparam int IDX_BITS = $clog2(SETS);
    localparam int WORD_W   = $bits(word_t);

    line_t                  lines [SETS];
    logic [IDX_BITS-1:0]    idx;
    logic [OFFSET_BITS-1:0] off;
    logic [IDX_BITS-1:0]    fill_idx;
    logic [IDX_BITS-1:0]    up_idx;    // lookup position, kept for a write hit
    logic [OFFSET_BITS-1:0] up_off;

    assign idx      = addr[OFFSET_BITS +: IDX_BITS];
    assign off      = addr[OFFSET_BITS-1:0];
    assign fill_idx = fill_addr[OFFSET_BITS +: IDX_BITS];

    always_ff @(posedge clk) begin
        if (lookup) begin
            word   <= lines[idx][off*WORD_W +: WORD_W];
            up_idx <= idx;
            up_off <= off;
        end
        if (fill) begin
            lines[fill_idx] <= fill_line;    // whole line from memory
        end else if (update) begin
            lines[up_idx][up_off*WORD_W +: WORD_W] <= update_word;
        end
    end

endmodule

`default_nettype wire

// ==== design/cache_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_ctrl #(
    parameter int SETS = 16
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   req,
    input  wire                   we,
    input  wire cache_pkg::addr_t addr,
    input  wire cache_pkg::word_t wdata,
    input  wire                   hit,
    input  wire cache_pkg::word_t word,
    input  wire cache_pkg::line_t mem_line,
    input  wire                   mem_ready,
    input  wire                   mem_busy,
    output cache_pkg::word_t      rdata,
    output logic                  busy,
    output logic                  done,
    output logic                  lookup,
    output logic                  fill,
    output logic                  update,
    output logic                  mem_rd,
    output logic                  mem_wr,
    output cache_pkg::addr_t      mem_addr,
    output cache_pkg::word_t      mem_wdata
);

    import cache_pkg::*;

    localparam int WORD_W = $bits(word_t);

    typedef enum logic [1:0] {
        idle,
        check,
        miss_wait,
        write_wait
    } state_t;

    state_t                 state;
    logic                   we_q;
    addr_t                  addr_q;
    word_t                  wdata_q;
    word_t                  rdata_q;
    logic                   sent;      // memory strobe out for this request
    logic                   done_q;
    logic                   read_hit;
    logic                   arrive;
    logic [OFFSET_BITS-1:0] off;

    // index field is taken straight from the address bits
    if (SETS < 2 || (SETS & (SETS - 1)) != 0) begin : g_sets_check
        $error("SETS must be a power of two");
    end

    ////////////////////
    // decode

    assign off      = addr_q[OFFSET_BITS-1:0];
    assign read_hit = (state == check) && !we_q && hit;
    assign arrive   = (state == miss_wait) && sent && mem_ready && !done_q;    // first ready cycle

    assign lookup = (state == idle) && req;
    assign fill   = arrive;
    assign update = (state == check) && we_q && hit;    // no write allocate

    assign mem_rd = !mem_busy && (((state == check) && !we_q && !hit) ||
                                  ((state == miss_wait) && !sent));
    assign mem_wr = !mem_busy && (((state == check) && we_q) ||
                                  ((state == write_wait) && !sent));

    assign mem_addr  = addr_q;
    assign mem_wdata = wdata_q;

    assign busy  = (state != idle);
    assign done  = read_hit || done_q;
    assign rdata = (state == check) ? word : rdata_q;

    ////////////////////
    // sequencing

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state  <= idle;
            we_q   <= 1'b0;
            sent   <= 1'b0;
            done_q <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (req) begin
                        state <= check;
                        we_q  <= we;
                    end
                end
                check: begin
                    sent <= mem_rd || mem_wr;    // memory may still be holding ready
                    if (read_hit) begin
                        state <= idle;
                    end else if (we_q) begin
                        state <= write_wait;
                    end else begin
                        state <= miss_wait;
                    end
                end
                miss_wait: begin
                    if (mem_rd) begin
                        sent <= 1'b1;
                    end
                    if (done_q) begin
                        state  <= idle;
                        done_q <= 1'b0;
                    end else if (arrive) begin
                        done_q <= 1'b1;
                    end
                end
                default: begin
                    if (mem_wr) begin
                        sent <= 1'b1;
                    end
                    if (done_q) begin
                        state  <= idle;
                        done_q <= 1'b0;
                    end else if (sent && !mem_busy) begin
                        done_q <= 1'b1;    // write has landed
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (lookup) begin
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if (arrive) begin
            rdata_q <= mem_line[off*WORD_W +: WORD_W];
        end
    end

    a_done_busy: assert property (@(posedge clk) disable iff (!rst)
        done |-> (state != idle) ##1 (state == idle));

endmodule

`default_nettype wire

// ==== design/cache_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_top #(
    parameter int SETS        = 16,
    parameter int MEM_LINES   = 256,
    parameter int READ_DELAY  = 10,
    parameter int WRITE_DELAY = 10,
    parameter int READY_HOLD  = 3
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   req,
    input  wire                   we,
    input  wire cache_pkg::addr_t addr,
    input  wire cache_pkg::word_t wdata,
    output cache_pkg::word_t      rdata,
    output logic                  busy,
    output logic                  done
);

    import cache_pkg::*;

    logic  lookup;
    logic  fill;
    logic  update;
    logic  hit;
    word_t word;
    logic  mem_rd;
    logic  mem_wr;
    addr_t mem_addr;
    word_t mem_wdata;
    line_t mem_line;
    logic  mem_ready;
    logic  mem_busy;

    ////////////////////
    // lookup side

    tag_store #(.SETS(SETS)) u_tags (
        .clk(clk), .rst(rst), .lookup(lookup), .addr(addr),
        .fill(fill), .fill_addr(mem_addr), .hit(hit)
    );

    data_store #(.SETS(SETS)) u_data (
        .clk(clk), .lookup(lookup), .addr(addr),
        .fill(fill), .fill_addr(mem_addr), .fill_line(mem_line),
        .update(update), .update_word(mem_wdata), .word(word)    // write data rides mem_wdata
    );

    ////////////////////
    // control and memory

    cache_ctrl #(.SETS(SETS)) u_ctrl (
        .clk(clk), .rst(rst), .req(req), .we(we), .addr(addr), .wdata(wdata),
        .hit(hit), .word(word), .mem_line(mem_line), .mem_ready(mem_ready),
        .mem_busy(mem_busy), .rdata(rdata), .busy(busy), .done(done),
        .lookup(lookup), .fill(fill), .update(update), .mem_rd(mem_rd),
        .mem_wr(mem_wr), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

    line_mem #(
        .MEM_LINES(MEM_LINES), .READ_DELAY(READ_DELAY),
        .WRITE_DELAY(WRITE_DELAY), .READY_HOLD(READY_HOLD)
    ) u_mem (
        .clk(clk), .rst(rst), .mem_rd(mem_rd), .mem_wr(mem_wr),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_line(mem_line),
        .mem_ready(mem_ready), .mem_busy(mem_busy)
    );

endmodule

`default_nettype wire

// ==== sim/clk_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module clk_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b0;    // active low, held for the first cycles
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/tb_cache.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_cache;

    import cache_pkg::*;

    localparam int MEM_LINES   = 256;
    localparam int READ_DELAY  = 10;
    localparam int WRITE_DELAY = 10;
    localparam int READY_HOLD  = 3;
    localparam int ADDR_BITS   = $clog2(MEM_LINES * WORDS_PER_LINE);    // keeps clear of aliasing
    localparam int FILL_WORDS  = 64;
    localparam int MIX_OPS     = 300;
    localparam int TOTAL_OPS   = 2 * FILL_WORDS + 2 + 4 + 7 + MIX_OPS;
    localparam int OP_CYCLES   = READ_DELAY + WRITE_DELAY + 2 * READY_HOLD + 4;
    localparam int CYCLE_LIMIT = TOTAL_OPS * OP_CYCLES + 20;

    wire         clk;
    wire         rst;
    logic        req;
    logic        we;
    addr_t       addr;
    word_t       wdata;
    word_t       rdata;
    logic        busy;
    logic        done;

    word_t       model [addr_t];    // expected memory contents
    addr_t       addrs [FILL_WORDS];
    logic [15:0] lfsr_state;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          cycle_count;

    clk_gen #(.PERIOD(8), .RESET_CYCLES(2)) u_clk (.clk(clk), .rst(rst));

    cache_top dut0 (
        .clk(clk), .rst(rst), .req(req), .we(we), .addr(addr), .wdata(wdata),
        .rdata(rdata), .busy(busy), .done(done)
    );

    ////////////////////
    // random source

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];    // x^16 + x^14 + x^13 + x^11 + 1
        return {s[14:0], fb};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    ////////////////////
    // client operations

    task automatic expect_busy(input logic level);
        assert (busy === level) else begin
            $display("Fail at %0t: busy got %b expected %b", $time, busy, level);
            errors++;
        end
    endtask

    task automatic run_op(input logic w, input addr_t a, input word_t d,
                          output word_t rd, output int lat);
        expect_busy(1'b0);
        req   = 1'b1;
        we    = w;
        addr  = a;
        wdata = d;
        @(posedge clk);
        #1;
        req = 1'b0;
        lat = 1;
        expect_busy(1'b1);
        while (done !== 1'b1) begin
            @(posedge clk);
            #1;
            lat++;
            expect_busy(1'b1);    // held through the done cycle
        end
        rd = rdata;
        @(posedge clk);    // controller returns to idle
        #1;
    endtask

    task automatic write_word(input addr_t a, input word_t d);
        word_t rd;
        int    lat;
        run_op(1'b1, a, d, rd, lat);
        model[a] = d;
    endtask

    task automatic read_check(input addr_t a, output int lat);
        word_t rd;
        run_op(1'b0, a, '0, rd, lat);
        assert (rd === model[a]) else begin
            $display("Fail at %0t: rdata for addr %h got %h expected %h",
                     $time, a, rd, model[a]);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start);
        tests_run++;
        if (errors == start) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - start);
        end
    endtask

    ////////////////////
    // watchdog

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run stopped after %0d cycles without finishing the tests", cycle_count);
        $display("test failed");
        $finish;
    end

    ////////////////////
    // tests

    initial begin
        int    lat;
        int    start;
        addr_t a;
        addr_t b;
        word_t d;
        req          = 1'b0;
        we           = 1'b0;
        addr         = '0;
        wdata        = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        lfsr_state   = 16'd35870;
        wait (rst === 1'b1);
        @(posedge clk);
        #1;

        start = errors;
        expect_busy(1'b0);
        assert (done === 1'b0) else begin
            $display("Fail at %0t: done got %b expected 0", $time, done);
            errors++;
        end
        report_test("reset", start);

        start = errors;
        for (int i = 0; i < FILL_WORDS; i++) begin
            addrs[i] = rand_bits(ADDR_BITS);
            write_word(addrs[i], rand_bits(32));
        end
        for (int i = 0; i < FILL_WORDS; i++) begin
            read_check(addrs[i], lat);
        end
        report_test("write then read back", start);

        start = errors;
        read_check(addrs[0], lat);
        read_check(addrs[0], lat);    // line is cached now
        assert (lat == 1) else begin
            $display("Fail at %0t: done latency got %0d expected 1", $time, lat);
            errors++;
        end
        report_test("hit latency", start);

        start = errors;
        a = addrs[1];
        b = a ^ 32'h1;    // neighbour word in the same line
        read_check(a, lat);
        write_word(b, rand_bits(32));
        read_check(a, lat);
        read_check(b, lat);
        report_test("write hit coherence", start);

        start = errors;
        a = addrs[2];
        b = a ^ (32'h1 << (ADDR_BITS - 2));    // same index, other tag
        write_word(b, rand_bits(32));
        for (int i = 0; i < 3; i++) begin
            read_check(a, lat);
            read_check(b, lat);
        end
        report_test("conflict eviction", start);

        start = errors;
        for (int i = 0; i < MIX_OPS; i++) begin
            d = rand_bits(1);
            a = rand_bits(ADDR_BITS);
            if (d[0] || !model.exists(a)) begin
                write_word(a, rand_bits(32));
            end else begin
                read_check(a, lat);
            end
        end
        report_test("random mix", start);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/cache_pkg.sv
design/line_mem.sv
design/tag_store.sv
design/data_store.sv
design/cache_ctrl.sv
design/cache_top.sv
sim/clk_gen.sv
sim/tb_cache.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cache testbench with Verilator

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_cache \
    && ./obj_dir/Vtb_cache | tee sim.log \
    || { echo "build or run error"; exit 1; }

grep -q "test failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "test passed" sim.log || { echo "no pass message in log"; exit 1; }
exit 0
